// ==== common/eth_tx_pkg.sv ====
package eth_tx_pkg;

    // Octet and CRC widths
    typedef logic [7:0]  byte_t;   // One frame octet on any stream or the PHY
    typedef logic [31:0] crc_t;    // Running CRC-32 register value

    // Fixed frame octets
    localparam byte_t ETH_PREAMBLE = 8'h55;   // Alternating ones and zeros
    localparam byte_t ETH_SFD      = 8'hD5;   // Start of frame delimiter
    localparam byte_t ETH_PAD      = 8'h00;   // Fill for short payloads

    // Frame lengths in octets
    localparam int PREAMBLE_BYTES  = 7;    // Preamble before the SFD
    localparam int MIN_FRAME_BYTES = 60;   // Payload plus pad, 64 less the FCS
    localparam int IFG_BYTES       = 12;   // 96 bit times at byte rate

    // CRC-32 in reflected form, LSB of each octet goes in first
    localparam crc_t CRC_INIT = 32'hFFFF_FFFF;
    localparam crc_t CRC_POLY = 32'hEDB8_8320;   // Bit reversed 0x04C11DB7

    // Transmit MAC phases, named after the octet that goes out next
    typedef enum logic [2:0] {
        ST_IDLE,       // Waiting for a source to offer a frame
        ST_PREAMBLE,   // Sending 0x55 octets
        ST_SFD,        // Sending the delimiter
        ST_PACKET,     // Passing payload octets through
        ST_PADDING,    // Zero fill up to the minimum
        ST_FCS,        // Four check octets, low byte first
        ST_GAP         // Idle line between frames
    } tx_state_t;

endpackage

// ==== common/byte_stream_if.sv ====
`timescale 1ns/1ps

// Byte wide stream with valid, last and ready handshake
interface byte_stream_if;

    eth_tx_pkg::byte_t data;   // Octet offered by the source
    logic              valid;  // Source has an octet
    logic              last;   // Final payload octet of the frame
    logic              ready;  // Sink takes the octet this edge

    // Producer side
    modport source (
        output data, valid, last,
        input  ready
    );

    // Consumer side
    modport sink (
        input  data, valid, last,
        output ready
    );

endinterface

// ==== hdl/crc32.sv ====
`timescale 1ns/1ps

// One octet step of the Ethernet CRC-32, reflected form
module crc32 (
    input  eth_tx_pkg::crc_t  crc_in,   // Register before this octet
    input  eth_tx_pkg::byte_t data,     // Octet to fold in
    output eth_tx_pkg::crc_t  crc_out,  // Register after this octet
    output eth_tx_pkg::crc_t  fcs       // Value sent on the wire for crc_in
);

    eth_tx_pkg::crc_t crc_acc;   // Shift register unrolled over 8 bits

    // Bit serial LFSR, LSB of the octet first
    always_comb begin
        crc_acc = crc_in;
        for (int i = 0; i < 8; i++) begin
            if (crc_acc[0] ^ data[i]) begin
                crc_acc = (crc_acc >> 1) ^ eth_tx_pkg::CRC_POLY;   // Feedback taps
            end else begin
                crc_acc = crc_acc >> 1;
            end
        end
    end

    assign crc_out = crc_acc;

    // Final complement, the MAC sends it low byte first
    assign fcs = ~crc_in;

endmodule

// ==== tx_mac/tx_mac.sv ====
`timescale 1ns/1ps

// Transmit MAC
// Wraps each stream frame in preamble, SFD, pad, FCS and an inter-frame gap
module tx_mac (
    input  logic              clk,
    input  logic              crc_reset,
    byte_stream_if.sink       s_in,        // Payload from the arbiter
    input  logic              phy_ready,   // Low freezes the whole MAC
    output eth_tx_pkg::byte_t phy_data,
    output logic              phy_dv
);

    eth_tx_pkg::tx_state_t state;   // Registered phase
    eth_tx_pkg::tx_state_t phase;   // Phase acting this cycle

    logic [3:0] byte_cnt;   // Preamble, FCS and gap position
    logic [6:0] len_cnt;    // Payload plus pad length, stops at the minimum
    logic       len_full;   // Minimum length reached
    logic       len_done;   // Octet going out now completes the minimum

    eth_tx_pkg::crc_t  crc_reg;    // Running CRC over payload and pad
    eth_tx_pkg::crc_t  crc_next;   // CRC with the current octet folded in
    eth_tx_pkg::crc_t  fcs_val;    // Complemented CRC for the FCS field
    eth_tx_pkg::byte_t crc_byte;   // Octet fed to the CRC step

    assign len_full = (len_cnt == 7'(eth_tx_pkg::MIN_FRAME_BYTES));
    assign len_done = (len_cnt >= 7'(eth_tx_pkg::MIN_FRAME_BYTES - 1));

    // Source dropping valid mid-frame ends the payload right away
    always_comb begin
        phase = state;
        if (state == eth_tx_pkg::ST_PACKET && !s_in.valid) begin
            phase = len_full ? eth_tx_pkg::ST_FCS : eth_tx_pkg::ST_PADDING;
        end
    end

    // Only payload octets come from the stream, the rest of the CRC input is pad
    assign crc_byte = (phase == eth_tx_pkg::ST_PACKET) ? s_in.data : eth_tx_pkg::ETH_PAD;

    crc32 crc32_inst (
        .crc_in  (crc_reg),
        .data    (crc_byte),
        .crc_out (crc_next),
        .fcs     (fcs_val)
    );

    // Take payload only in packet phase and only when the PHY moves
    assign s_in.ready = (state == eth_tx_pkg::ST_PACKET) && phy_ready;

    always_ff @(posedge clk) begin
        if (crc_reset) begin
            state    <= eth_tx_pkg::ST_IDLE;
            phy_dv   <= 1'b0;
            phy_data <= '0;
            byte_cnt <= '0;
            len_cnt  <= '0;
        end else if (phy_ready) begin   // Back-pressure holds every register
            case (phase)
                eth_tx_pkg::ST_IDLE: begin
                    phy_dv <= 1'b0;
                    if (s_in.valid) begin
                        // First preamble octet leaves on this edge
                        phy_dv   <= 1'b1;
                        phy_data <= eth_tx_pkg::ETH_PREAMBLE;
                        byte_cnt <= 4'd1;
                        len_cnt  <= '0;
                        crc_reg  <= eth_tx_pkg::CRC_INIT;   // Fresh CRC per frame
                        state    <= eth_tx_pkg::ST_PREAMBLE;
                    end
                end

                eth_tx_pkg::ST_PREAMBLE: begin
                    phy_data <= eth_tx_pkg::ETH_PREAMBLE;
                    byte_cnt <= byte_cnt + 4'd1;
                    if (byte_cnt == 4'(eth_tx_pkg::PREAMBLE_BYTES - 1)) begin
                        state <= eth_tx_pkg::ST_SFD;   // Seventh octet goes now
                    end
                end

                eth_tx_pkg::ST_SFD: begin
                    phy_data <= eth_tx_pkg::ETH_SFD;
                    byte_cnt <= '0;   // FCS index starts from zero
                    state    <= eth_tx_pkg::ST_PACKET;
                end

                eth_tx_pkg::ST_PACKET: begin
                    phy_data <= s_in.data;   // Octet out one cycle after transfer
                    crc_reg  <= crc_next;
                    if (!len_full) begin
                        len_cnt <= len_cnt + 7'd1;
                    end
                    if (s_in.last) begin
                        state <= len_done ? eth_tx_pkg::ST_FCS : eth_tx_pkg::ST_PADDING;
                    end
                end

                eth_tx_pkg::ST_PADDING: begin
                    // Also entered straight from packet when valid drops
                    phy_data <= eth_tx_pkg::ETH_PAD;
                    crc_reg  <= crc_next;
                    len_cnt  <= len_cnt + 7'd1;
                    state    <= len_done ? eth_tx_pkg::ST_FCS : eth_tx_pkg::ST_PADDING;
                end

                eth_tx_pkg::ST_FCS: begin
                    phy_data <= fcs_val[{byte_cnt[1:0], 3'b000} +: 8];   // LSB first
                    byte_cnt <= byte_cnt + 4'd1;
                    state    <= eth_tx_pkg::ST_FCS;
                    if (byte_cnt == 4'd3) begin
                        byte_cnt <= '0;
                        state    <= eth_tx_pkg::ST_GAP;
                    end
                end

                eth_tx_pkg::ST_GAP: begin
                    phy_dv   <= 1'b0;   // First gap edge drops dv
                    byte_cnt <= byte_cnt + 4'd1;
                    if (byte_cnt == 4'(eth_tx_pkg::IFG_BYTES - 1)) begin
                        byte_cnt <= '0;
                        state    <= eth_tx_pkg::ST_IDLE;
                    end
                end

                default: begin
                    phy_dv <= 1'b0;
                    state  <= eth_tx_pkg::ST_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== hdl/tx_stream_arbiter.sv ====
`timescale 1ns/1ps

// Two source round-robin arbiter, grant held for a whole frame
module tx_stream_arbiter (
    input  logic          clk,
    input  logic          crc_reset,
    byte_stream_if.sink   src0,
    byte_stream_if.sink   src1,
    byte_stream_if.source m_out
);

    logic grant;         // Source currently routed to m_out
    logic locked;        // Frame in progress on the granted source
    logic last_served;   // Source that sent the most recent whole frame
    logic xfer;          // Octet moves on m_out this edge
    logic pick_valid;    // Preferred source is waiting

    // Zero latency mux toward the MAC
    assign m_out.data  = grant ? src1.data  : src0.data;
    assign m_out.valid = grant ? src1.valid : src0.valid;
    assign m_out.last  = grant ? src1.last  : src0.last;

    // Ready back to the granted source only
    assign src0.ready = m_out.ready && !grant;
    assign src1.ready = m_out.ready &&  grant;

    assign xfer = m_out.valid && m_out.ready;

    // Source that did not go last gets first pick
    assign pick_valid = last_served ? src0.valid : src1.valid;

    always_ff @(posedge clk) begin
        if (crc_reset) begin
            grant       <= 1'b0;
            locked      <= 1'b0;
            last_served <= 1'b1;   // Source 0 wins the first tie
        end else if (xfer) begin
            if (m_out.last) begin
                // Frame done, hand over if the other side waits
                locked      <= 1'b0;
                last_served <= grant;
                if (grant ? src0.valid : src1.valid) begin
                    grant <= ~grant;
                end
            end else begin
                locked <= 1'b1;   // First octet pins the grant
            end
        end else if (!locked && !m_out.valid) begin
            // Granted side idle, move to whoever is waiting
            if (pick_valid) begin
                grant <= ~last_served;
            end else if (src0.valid || src1.valid) begin
                grant <= last_served;
            end
        end
    end

endmodule

// ==== hdl/eth_tx_top.sv ====
`timescale 1ns/1ps

// Two byte stream sources sharing one transmit MAC
module eth_tx_top (
    input  logic              clk,
    input  logic              crc_reset,
    // Source 0
    input  eth_tx_pkg::byte_t src0_data,
    input  logic              src0_valid,
    input  logic              src0_last,
    output logic              src0_ready,
    // Source 1
    input  eth_tx_pkg::byte_t src1_data,
    input  logic              src1_valid,
    input  logic              src1_last,
    output logic              src1_ready,
    // PHY side
    input  logic              phy_ready,
    output eth_tx_pkg::byte_t phy_data,
    output logic              phy_dv
);

    byte_stream_if src0_if ();      // Source 0 into the arbiter
    byte_stream_if src1_if ();      // Source 1 into the arbiter
    byte_stream_if arb_to_mac ();   // Granted stream into the MAC

    // Plain ports onto the stream bundles
    assign src0_if.data  = src0_data;
    assign src0_if.valid = src0_valid;
    assign src0_if.last  = src0_last;
    assign src0_ready    = src0_if.ready;

    assign src1_if.data  = src1_data;
    assign src1_if.valid = src1_valid;
    assign src1_if.last  = src1_last;
    assign src1_ready    = src1_if.ready;

    tx_stream_arbiter tx_stream_arbiter_inst (
        .clk       (clk),
        .crc_reset (crc_reset),
        .src0      (src0_if),
        .src1      (src1_if),
        .m_out     (arb_to_mac)
    );

    tx_mac tx_mac_inst (
        .clk       (clk),
        .crc_reset (crc_reset),
        .s_in      (arb_to_mac),
        .phy_ready (phy_ready),
        .phy_data  (phy_data),
        .phy_dv    (phy_dv)
    );

endmodule

// ==== verif/eth_tx_checker.sv ====
`timescale 1ns/1ps

// Port level protocol checks bound into eth_tx_top
module eth_tx_checker (
    input logic              clk,
    input logic              crc_reset,
    input logic              src0_ready,
    input logic              src1_ready,
    input logic              phy_ready,
    input eth_tx_pkg::byte_t phy_data,
    input logic              phy_dv
);

    logic [4:0] low_run;   // Run of dv low cycles capped at the gap length

    always_ff @(posedge clk) begin
        if (crc_reset) begin
            low_run <= 5'(eth_tx_pkg::IFG_BYTES);   // Reset acts as a full gap
        end else if (phy_dv) begin
            low_run <= '0;
        end else if (low_run < 5'(eth_tx_pkg::IFG_BYTES)) begin
            low_run <= low_run + 5'd1;
        end
    end

    reset_idle: assert property (@(posedge clk)
        crc_reset |=> !phy_dv && !src0_ready && !src1_ready)
        else $error("phy_dv or a source ready is high right after reset");

    // Back-pressure freezes the PHY side
    stall_hold: assert property (@(posedge clk) disable iff (crc_reset)
        !phy_ready |=> $stable(phy_data) && $stable(phy_dv))
        else $error("PHY outputs moved during a stall");

    one_grant: assert property (@(posedge clk) disable iff (crc_reset)
        !(src0_ready && src1_ready))
        else $error("Both source readies high together");

    gap_length: assert property (@(posedge clk) disable iff (crc_reset)
        $rose(phy_dv) |-> low_run >= 5'(eth_tx_pkg::IFG_BYTES))
        else $error("Inter-frame gap shorter than the minimum");

endmodule

bind eth_tx_top eth_tx_checker eth_tx_checker_inst (
    .clk        (clk),
    .crc_reset  (crc_reset),
    .src0_ready (src0_ready),
    .src1_ready (src1_ready),
    .phy_ready  (phy_ready),
    .phy_data   (phy_data),
    .phy_dv     (phy_dv)
);

// ==== verif/tb_eth_tx.sv ====
`timescale 1ns/1ps

module tb_eth_tx;

    localparam int FRAMES    = 5;       // Frames per source
    localparam int RUN_LIMIT = 20000;   // Cycles allowed for every frame to arrive

    logic              clk = 1'b0;
    logic              crc_reset;
    logic [1:0][7:0]   s_data;          // Index is the source number
    logic [1:0]        s_valid;
    logic [1:0]        s_last;
    wire  [1:0]        s_ready;
    logic              phy_ready;
    eth_tx_pkg::byte_t phy_data;
    logic              phy_dv;

    eth_tx_pkg::byte_t pay_mem [2][FRAMES][80];
    int                pay_len [2][FRAMES];
    int                fi [2];          // Frame on offer per source
    int                bi [2];          // Octet within that frame
    int                gap [2];         // Idle cycles before the next frame
    logic [1:0]        xfer;            // Handshakes at the coming edge
    int                pend_src [$];    // Started frames with the oldest first
    int                pend_frm [$];
    eth_tx_pkg::byte_t rx_q [$];        // PHY burst being gathered
    eth_tx_pkg::byte_t exp_q [$];
    int                cur_src;         // -1 between frames
    int                alt_src;         // Source owed the next frame or -1
    int                frames_done;
    int                low_cycles;      // Run of dv low cycles including stalls
    logic              prev_dv;

    always #2 clk = ~clk;

    eth_tx_top eth_tx_top_inst (
        .clk        (clk),
        .crc_reset  (crc_reset),
        .src0_data  (s_data[0]),
        .src0_valid (s_valid[0]),
        .src0_last  (s_last[0]),
        .src0_ready (s_ready[0]),
        .src1_data  (s_data[1]),
        .src1_valid (s_valid[1]),
        .src1_last  (s_last[1]),
        .src1_ready (s_ready[1]),
        .phy_ready  (phy_ready),
        .phy_data   (phy_data),
        .phy_dv     (phy_dv)
    );

    task automatic stop_with_failure(input string line);
        $display("%s", line);
        $display("Testbench failed");
        $fatal(1);
    endtask

    // Ethernet CRC in MSB first form with octets fed LSB first and the result mirrored
    function automatic eth_tx_pkg::crc_t reference_fcs(input eth_tx_pkg::byte_t bytes [$]);
        eth_tx_pkg::crc_t crc;
        eth_tx_pkg::crc_t mirrored;
        logic             fb;
        crc = 32'hFFFF_FFFF;
        foreach (bytes[n]) begin
            for (int i = 0; i < 8; i++) begin
                fb  = crc[31] ^ bytes[n][i];
                crc = {crc[30:0], 1'b0} ^ (fb ? 32'h04C1_1DB7 : 32'h0);   // Normal polynomial
            end
        end
        for (int i = 0; i < 32; i++) begin
            mirrored[i] = crc[31 - i];
        end
        return ~mirrored;
    endfunction

    // Expected frame is preamble and SFD then padded payload then FCS low octet first
    task automatic build_expected(input int s, input int f);
        eth_tx_pkg::byte_t body [$];
        eth_tx_pkg::crc_t  fcs;
        for (int i = 0; i < pay_len[s][f]; i++) begin
            body.push_back(pay_mem[s][f][i]);
        end
        while (body.size() < 60) begin
            body.push_back(8'h00);
        end
        fcs = reference_fcs(body);
        exp_q.delete();
        for (int i = 0; i < 8; i++) begin
            exp_q.push_back((i < 7) ? 8'h55 : 8'hD5);
        end
        foreach (body[i]) begin
            exp_q.push_back(body[i]);
        end
        for (int k = 0; k < 4; k++) begin
            exp_q.push_back(fcs[8*k +: 8]);
        end
    endtask

    task automatic check_frame();
        assert (pend_src.size() > 0) else stop_with_failure(
            $sformatf("ERROR %0t: PHY frame with no source frame behind it", $time));
        build_expected(pend_src.pop_front(), pend_frm.pop_front());
        assert (rx_q.size() == exp_q.size()) else stop_with_failure($sformatf(
            "ERROR %0t: frame %0d is %0d octets long, expected %0d",
            $time, frames_done, rx_q.size(), exp_q.size()));
        foreach (exp_q[i]) begin
            assert (rx_q[i] == exp_q[i]) else stop_with_failure($sformatf(
                "ERROR %0t: frame %0d octet %0d is %02h, expected %02h",
                $time, frames_done, i, rx_q[i], exp_q[i]));
        end
        rx_q.delete();
        frames_done++;
    endtask

    // Steps past last cycle's handshakes and drives the next octet on the falling edge
    task automatic advance_sources();
        for (int s = 0; s < 2; s++) begin
            if (xfer[s]) begin
                bi[s]++;
                if (bi[s] == pay_len[s][fi[s]]) begin
                    fi[s]++;
                    bi[s]  = 0;
                    gap[s] = int'($urandom_range(6, 0));   // Idle only between frames
                end
            end else if (gap[s] > 0) begin
                gap[s]--;
            end
            s_valid[s] = (fi[s] < FRAMES) && (gap[s] == 0);
            s_data[s]  = s_valid[s] ? pay_mem[s][fi[s]][bi[s]] : 8'h00;
            s_last[s]  = s_valid[s] && (bi[s] == pay_len[s][fi[s]] - 1);
        end
    endtask

    // Samples mid cycle once all DUT outputs have settled
    task automatic sample_cycle();
        xfer = s_valid & s_ready;
        for (int s = 0; s < 2; s++) begin
            if (xfer[s]) begin
                if (bi[s] == 0) begin
                    assert (cur_src < 0) else stop_with_failure($sformatf(
                        "ERROR %0t: source %0d started inside another frame", $time, s));
                    assert (alt_src < 0 || alt_src == s) else stop_with_failure($sformatf(
                        "ERROR %0t: source %0d went twice while both waited", $time, s));
                    pend_src.push_back(s);
                    pend_frm.push_back(fi[s]);
                    cur_src = s;
                    alt_src = -1;
                end
                assert (cur_src == s) else stop_with_failure($sformatf(
                    "ERROR %0t: source %0d interleaved into source %0d", $time, s, cur_src));
                if (s_last[s]) begin
                    cur_src = -1;
                    alt_src = s_valid[1 - s] ? 1 - s : -1;   // Other side waiting gets the turn
                end
            end
        end
        if (phy_dv && !prev_dv && frames_done > 0) begin
            assert (low_cycles >= eth_tx_pkg::IFG_BYTES) else stop_with_failure($sformatf(
                "ERROR %0t: gap of %0d cycles before frame %0d", $time, low_cycles, frames_done));
        end
        if (phy_dv && phy_ready) begin
            rx_q.push_back(phy_data);   // Octet taken by the PHY this edge
        end
        if (!phy_dv && rx_q.size() > 0) begin
            check_frame();
        end
        low_cycles = phy_dv ? 0 : low_cycles + 1;
        prev_dv    = phy_dv;
    endtask

    initial begin
        int cycle;
        void'($urandom(28036));
        for (int s = 0; s < 2; s++) begin
            for (int f = 0; f < FRAMES; f++) begin
                if (f == 0) begin
                    pay_len[s][f] = int'($urandom_range(59, 1));    // Short payload gets padding
                end else if (f == 1) begin
                    pay_len[s][f] = 60;                             // Exactly the minimum
                end else if (f == 2) begin
                    pay_len[s][f] = int'($urandom_range(80, 61));   // No padding
                end else begin
                    pay_len[s][f] = int'($urandom_range(80, 1));
                end
                for (int b = 0; b < 80; b++) begin
                    pay_mem[s][f][b] = 8'($urandom);
                end
            end
            fi[s]  = 0;
            bi[s]  = 0;
            gap[s] = 0;
        end
        crc_reset   = 1'b1;
        s_data      = '0;
        s_valid     = '0;
        s_last      = '0;
        phy_ready   = 1'b1;
        xfer        = '0;
        cur_src     = -1;
        alt_src     = -1;
        frames_done = 0;
        low_cycles  = 0;
        prev_dv     = 1'b0;
        cycle       = 0;
        repeat (16) @(negedge clk);
        crc_reset = 1'b0;
        while (frames_done < 2 * FRAMES) begin
            @(negedge clk);
            cycle++;
            if (cycle > RUN_LIMIT) begin
                stop_with_failure("Timeout: not every frame reached the PHY in time");
            end
            advance_sources();
            phy_ready = ($urandom_range(3, 0) != 0);   // Stall roughly one cycle in four
            #1;
            sample_cycle();
        end
        $display("Testbench passed");
        $finish;
    end

endmodule

// ==== filelist.f ====
common/eth_tx_pkg.sv
common/byte_stream_if.sv
hdl/crc32.sv
tx_mac/tx_mac.sv
hdl/tx_stream_arbiter.sv
hdl/eth_tx_top.sv
verif/eth_tx_checker.sv
verif/tb_eth_tx.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_eth_tx
FILELIST  = filelist.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	! grep -q "Testbench failed" $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
